// ==== he_pkg.sv ====
// --------------------------------------------------
// Histogram equalization shared definitions
// Sizes, FSM encoding and the control bundle
// --------------------------------------------------
`default_nettype none

package he_pkg;

	// --------------------------------------------------
	// Sizes
	// --------------------------------------------------
	localparam int WINDOW_SIZE = 8;
	localparam int PIXEL_W = 8;
	localparam int RANK_W = 8;
	localparam int RANK_MAX = 255;
	// Wide enough to also hold WINDOW_SIZE itself
	localparam int IDX_W = 4;

	typedef logic [PIXEL_W-1:0] pixel_t;
	typedef logic [RANK_W-1:0] rank_t;
	typedef logic [IDX_W-1:0] idx_t;

	// One rank per window pixel, lane 0 in the low byte
	typedef rank_t [WINDOW_SIZE-1:0] rank_vec_t;

	// --------------------------------------------------
	// Sequence FSM
	// --------------------------------------------------
	typedef enum logic [1:0] {
		IDLE = 2'b00,
		LOAD = 2'b01,
		RANK = 2'b11,
		EMIT = 2'b10
	} he_state_t;

	// Control bundle from sequencer to datapath and mapper
	typedef struct packed {
		logic load;
		logic rank_en;
		logic rank_clr;
		logic emit;
		idx_t sel;
	} he_ctrl_t;

endpackage

`default_nettype wire

// ==== he_control.sv ====
// --------------------------------------------------
// Histogram equalization sequencer
// Steps through load, rank and emit phases of a frame
// and drives the control bundle
// --------------------------------------------------
`default_nettype none

module he_control (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             in_valid,
	output he_pkg::he_ctrl_t ctrl
);
	import he_pkg::*;

	he_state_t state;
	he_state_t state_nxt;
	// Loaded pixels in LOAD, emitted pixels in EMIT
	idx_t      cnt;
	idx_t      cnt_nxt;

	// --------------------------------------------------
	// State and position registers
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin : state_seq
		if (!rst_n) begin
			state <= IDLE;
			cnt <= '0;
		end else begin
			state <= state_nxt;
			cnt <= cnt_nxt;
		end
	end

	// --------------------------------------------------
	// Next state
	// --------------------------------------------------
	always_comb begin : next_state_comb
		state_nxt = state;
		cnt_nxt = cnt;
		case (state)
			IDLE: begin
				// First window pixel is taken in this cycle
				if (in_valid) begin
					state_nxt = LOAD;
					cnt_nxt = idx_t'(1);
				end
			end
			LOAD: begin
				if (cnt == idx_t'(WINDOW_SIZE - 1)) begin
					state_nxt = RANK;
					cnt_nxt = '0;
				end else begin
					cnt_nxt = cnt + idx_t'(1);
				end
			end
			RANK: begin
				// Stream ends on the first low cycle
				if (!in_valid) begin
					state_nxt = EMIT;
				end
			end
			EMIT: begin
				if (cnt == idx_t'(WINDOW_SIZE - 1)) begin
					state_nxt = IDLE;
					cnt_nxt = '0;
				end else begin
					cnt_nxt = cnt + idx_t'(1);
				end
			end
			default: begin
				state_nxt = IDLE;
				cnt_nxt = '0;
			end
		endcase
	end

	// --------------------------------------------------
	// Control outputs
	// --------------------------------------------------
	always_comb begin : ctrl_comb
		ctrl = '0;
		case (state)
			IDLE: begin
				// Ranks held at zero while waiting for a frame
				ctrl.rank_clr = 1'b1;
				ctrl.load = in_valid;
			end
			LOAD: begin
				ctrl.load = 1'b1;
			end
			RANK: begin
				ctrl.rank_en = in_valid;
			end
			EMIT: begin
				ctrl.emit = 1'b1;
				ctrl.sel = cnt;
			end
			default: begin
				ctrl = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== window_rank.sv ====
// --------------------------------------------------
// Window store and rank counters
// Holds the eight window pixels and counts stream
// pixels at or below each of them
// --------------------------------------------------
`default_nettype none

module window_rank (
	input  logic              clk,
	input  logic              rst_n,
	input  he_pkg::pixel_t    in_image,
	input  he_pkg::he_ctrl_t  ctrl,
	output he_pkg::rank_vec_t ranks
);
	import he_pkg::*;

	pixel_t win [WINDOW_SIZE];

	// --------------------------------------------------
	// Window shift register
	// --------------------------------------------------
	// New pixel enters at the top and walks down, so the
	// first loaded pixel ends up in position 0
	always_ff @(posedge clk) begin : window_shift
		if (ctrl.load) begin
			for (int i = 0; i < WINDOW_SIZE - 1; i++) begin
				win[i] <= win[i + 1];
			end
			win[WINDOW_SIZE-1] <= in_image;
		end
	end

	// --------------------------------------------------
	// Rank lanes
	// --------------------------------------------------
	genvar k;
	generate
		for (k = 0; k < WINDOW_SIZE; k++) begin : g_lane
			rank_t rank_q;
			logic  le_hit;
			logic  saturated;

			// Equal values count too
			assign le_hit = (in_image <= win[k]);
			assign saturated = (rank_q == rank_t'(RANK_MAX));

			always_ff @(posedge clk or negedge rst_n) begin : rank_seq
				if (!rst_n) begin
					rank_q <= '0;
				end else if (ctrl.rank_clr) begin
					rank_q <= '0;
				end else if (ctrl.rank_en && le_hit && !saturated) begin
					rank_q <= rank_q + rank_t'(1);
				end
			end

			assign ranks[k] = rank_q;
		end
	endgenerate

endmodule

`default_nettype wire

// ==== out_mapper.sv ====
// --------------------------------------------------
// Output mapper
// Picks one rank, maps it to rank minus one and
// registers the result
// --------------------------------------------------
`default_nettype none

module out_mapper (
	input  logic              clk,
	input  logic              rst_n,
	input  he_pkg::he_ctrl_t  ctrl,
	input  he_pkg::rank_vec_t ranks,
	output logic              out_valid,
	output he_pkg::pixel_t    out_image
);
	import he_pkg::*;

	rank_t  sel_rank;
	pixel_t mapped;

	// Rank mux by window index
	always_comb begin : rank_select
		sel_rank = '0;
		for (int i = 0; i < WINDOW_SIZE; i++) begin
			if (ctrl.sel == idx_t'(i)) begin
				sel_rank = ranks[i];
			end
		end
	end

	// Zero rank stays zero
	assign mapped = (sel_rank == '0) ? '0 : pixel_t'(sel_rank - rank_t'(1));

	always_ff @(posedge clk or negedge rst_n) begin : out_seq
		if (!rst_n) begin
			out_valid <= 1'b0;
			out_image <= '0;
		end else begin
			out_valid <= ctrl.emit;
			out_image <= ctrl.emit ? mapped : '0;
		end
	end

endmodule

`default_nettype wire

// ==== he_top.sv ====
// --------------------------------------------------
// Histogram equalization engine top level
// Sequencer, window/rank datapath and output mapper
// --------------------------------------------------
`default_nettype none

module he_top (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           in_valid,
	input  he_pkg::pixel_t in_image,
	output logic           out_valid,
	output he_pkg::pixel_t out_image
);
	import he_pkg::*;

	he_ctrl_t  ctrl;
	rank_vec_t ranks;

	// --------------------------------------------------
	// Sequence control
	// --------------------------------------------------
	he_control u_control (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (in_valid),
		.ctrl     (ctrl)
	);

	// --------------------------------------------------
	// Window and rank datapath
	// --------------------------------------------------
	window_rank u_window_rank (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_image (in_image),
		.ctrl     (ctrl),
		.ranks    (ranks)
	);

	// Output stage, one register after the emit cycle
	out_mapper u_out_mapper (
		.clk       (clk),
		.rst_n     (rst_n),
		.ctrl      (ctrl),
		.ranks     (ranks),
		.out_valid (out_valid),
		.out_image (out_image)
	);

endmodule

`default_nettype wire

// ==== he_asserts.sv ====
// --------------------------------------------------
// Protocol checks on the engine outputs
// --------------------------------------------------
`default_nettype none

module he_asserts (
	input logic           clk,
	input logic           rst_n,
	input logic           in_valid,
	input logic           out_valid,
	input he_pkg::pixel_t out_image
);
	import he_pkg::*;

	// Consecutive out_valid samples so far
	idx_t run_len;

	always_ff @(posedge clk or negedge rst_n) begin : run_count
		if (!rst_n) begin
			run_len <= '0;
		end else if (out_valid) begin
			run_len <= run_len + idx_t'(1);
		end else begin
			run_len <= '0;
		end
	end

	a_valid_max: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> run_len < idx_t'(WINDOW_SIZE))
		else $error("out_valid held longer than %0d cycles", WINDOW_SIZE);

	a_valid_len: assert property (@(posedge clk) disable iff (!rst_n)
		(!out_valid && run_len != '0) |-> run_len == idx_t'(WINDOW_SIZE))
		else $error("out_valid run of %0d cycles", run_len);

	a_idle_zero: assert property (@(posedge clk) disable iff (!rst_n)
		!out_valid |-> out_image == '0)
		else $error("out_image nonzero while out_valid low");

	a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> !in_valid)
		else $error("in_valid high during output phase");

endmodule

bind he_top he_asserts u_asserts (
	.clk       (clk),
	.rst_n     (rst_n),
	.in_valid  (in_valid),
	.out_valid (out_valid),
	.out_image (out_image)
);

`default_nettype wire

// ==== tb_he.sv ====
// --------------------------------------------------
// Testbench for the histogram equalization engine
// Random and directed frames checked against a
// reference model of the rank mapping
// --------------------------------------------------
`default_nettype none

module tb_he;
	import he_pkg::*;

	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 16;
	localparam int DRIVE_DELAY = 2;
	localparam int unsigned SEED = 32'hb9d8;
	localparam int N_RANDOM = 24;
	localparam int STREAM_MIN = 1;
	localparam int STREAM_MAX = 40;
	localparam int SAT_LEN = 300;
	localparam int N_DIRECTED = 4;
	localparam int TOTAL_FRAMES = N_RANDOM + N_DIRECTED;
	// Window, longest stream, end cycle, emit phase and idle gap
	localparam int MAX_FRAME_CYCLES = WINDOW_SIZE + SAT_LEN + 1 + WINDOW_SIZE + 8;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + TOTAL_FRAMES * MAX_FRAME_CYCLES + 200;

	logic   clk;
	logic   rst_n;
	logic   in_valid;
	pixel_t in_image;
	logic   out_valid;
	pixel_t out_image;

	// Frame under construction
	pixel_t frame_win [WINDOW_SIZE];
	pixel_t frame_stream [$];
	// Expected outputs in emit order
	pixel_t exp_q [$];
	int frames_sent = 0;
	int frames_checked = 0;

	he_top UUT (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_image  (in_image),
		.out_valid (out_valid),
		.out_image (out_image)
	);

	initial begin : clock_gen
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// --------------------------------------------------
	// Failure reporting
	// --------------------------------------------------
	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string sig, input int got, input int expv);
		stop_with_failure($sformatf("CHECK FAILED at time %0t: %s is %0d, expected %0d",
			$time, sig, got, expv));
	endtask

	// --------------------------------------------------
	// Reference model
	// --------------------------------------------------
	// Rank is the count of stream pixels at or below the window
	// pixel, capped at 255; output is rank minus one, floor 0
	function automatic void ref_expected(input pixel_t win [WINDOW_SIZE],
			input pixel_t stream [$], output pixel_t expected [WINDOW_SIZE]);
		int cnt;
		for (int k = 0; k < WINDOW_SIZE; k++) begin
			cnt = 0;
			foreach (stream[j]) begin
				if (stream[j] <= win[k] && cnt < RANK_MAX) begin
					cnt++;
				end
			end
			expected[k] = (cnt > 0) ? pixel_t'(cnt - 1) : '0;
		end
	endfunction

	// --------------------------------------------------
	// Stimulus helpers
	// --------------------------------------------------
	task automatic fill_random_window();
		for (int k = 0; k < WINDOW_SIZE; k++) begin
			frame_win[k] = pixel_t'($urandom_range(255, 0));
		end
	endtask

	task automatic fill_random_stream(input int len);
		frame_stream.delete();
		repeat (len) begin
			frame_stream.push_back(pixel_t'($urandom_range(255, 0)));
		end
	endtask

	task automatic fill_const_stream(input int len, input pixel_t value);
		frame_stream.delete();
		repeat (len) begin
			frame_stream.push_back(value);
		end
	endtask

	// Drives one frame after gap idle cycles and waits until
	// all of its outputs have been compared
	task automatic run_frame(input int gap);
		pixel_t expected [WINDOW_SIZE];
		ref_expected(frame_win, frame_stream, expected);
		for (int k = 0; k < WINDOW_SIZE; k++) begin
			exp_q.push_back(expected[k]);
		end
		frames_sent++;
		repeat (gap) @(posedge clk);
		for (int k = 0; k < WINDOW_SIZE; k++) begin
			@(posedge clk);
			#(DRIVE_DELAY);
			in_valid = 1'b1;
			in_image = frame_win[k];
		end
		foreach (frame_stream[j]) begin
			@(posedge clk);
			#(DRIVE_DELAY);
			in_image = frame_stream[j];
		end
		@(posedge clk);
		#(DRIVE_DELAY);
		in_valid = 1'b0;
		in_image = '0;
		wait (frames_checked == frames_sent);
	endtask

	task automatic check_idle(input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			assert (out_valid == 1'b0)
			else stop_with_failure($sformatf("out_valid high at time %0t with no frame sent",
				$time));
			assert (out_image == '0)
			else report_mismatch("out_image", int'(out_image), 0);
		end
	endtask

	// --------------------------------------------------
	// Output comparison
	// --------------------------------------------------
	initial begin : compare_outputs
		pixel_t expected;
		forever begin
			@(negedge clk);
			if (rst_n && out_valid) begin
				for (int k = 0; k < WINDOW_SIZE; k++) begin
					if (k > 0) begin
						@(negedge clk);
					end
					assert (out_valid)
					else stop_with_failure($sformatf("out_valid fell after %0d outputs at time %0t",
						k, $time));
					assert (exp_q.size() > 0)
					else stop_with_failure("out_valid high with no output expected");
					expected = exp_q.pop_front();
					assert (out_image == expected)
					else report_mismatch("out_image", int'(out_image), int'(expected));
				end
				frames_checked++;
			end else if (rst_n) begin
				assert (out_image == '0)
				else report_mismatch("out_image", int'(out_image), 0);
			end
		end
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		stop_with_failure($sformatf("Timeout: %0d of %0d frames checked after %0d cycles",
			frames_checked, TOTAL_FRAMES, WATCHDOG_CYCLES));
	end

	// --------------------------------------------------
	// Main sequence
	// --------------------------------------------------
	initial begin : main_seq
		void'($urandom(SEED));
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_image = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		#(DRIVE_DELAY);
		rst_n = 1'b1;

		// Quiet outputs before the first frame
		check_idle(10);

		// Random frames, some back to back
		for (int f = 0; f < N_RANDOM; f++) begin
			fill_random_window();
			fill_random_stream($urandom_range(STREAM_MAX, STREAM_MIN));
			run_frame($urandom_range(3, 0));
		end

		// Empty stream gives all zeros
		fill_random_window();
		frame_stream.delete();
		run_frame(2);

		// Long dark stream saturates every rank
		for (int k = 0; k < WINDOW_SIZE; k++) begin
			frame_win[k] = 8'd255;
		end
		fill_const_stream(SAT_LEN, 8'd0);
		run_frame(1);

		// Stream holds every window value, so equal pixels count
		frame_stream.delete();
		for (int k = 0; k < WINDOW_SIZE; k++) begin
			frame_win[k] = pixel_t'(16 * (k + 1));
			frame_stream.push_back(pixel_t'(16 * (k + 1)));
		end
		frame_stream.push_back(8'd0);
		frame_stream.push_back(8'd255);
		run_frame(0);

		// Back to back with no idle gap, ranks must restart
		for (int k = 0; k < WINDOW_SIZE; k++) begin
			frame_win[k] = pixel_t'(16 * (WINDOW_SIZE - k));
		end
		fill_random_stream(20);
		run_frame(0);

		check_idle(4);
		if (exp_q.size() != 0 || frames_checked != TOTAL_FRAMES) begin
			stop_with_failure($sformatf("Run ended with %0d frames checked and %0d outputs left",
				frames_checked, exp_q.size()));
		end else begin
			$display("Test completed successfully");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== compile.f ====
he_pkg.sv
he_control.sv
window_rank.sv
out_mapper.sv
he_top.sv
he_asserts.sv
tb_he.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_he
FILELIST   := compile.f
BUILD_DIR  := obj_dir
VFLAGS     := --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only --timing --assert --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
